/* display_macros.svh */
// ====================
// Video timing and frame buffer sizes, shared by the RTL and the testbench
// ====================
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

// Horizontal timing in pixels
`define H_ACTIVE 320
`define H_FRONT 8
`define H_SYNC 32
`define H_BACK 40
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_ACTIVE 192
`define V_FRONT 3
`define V_SYNC 4
`define V_BACK 11
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// Counter widths, sized for the totals above
`define H_CNT_W 9
`define V_CNT_W 8

// Frame buffer, two pixels per read word
`define FB_PIXELS 61440
`define FB_WORDS 30720
`define FB_ADDR_W 15
`define FB_WADDR_W (`FB_ADDR_W + 1)

`define BAR_WIDTH 40

`endif

/* displayPkg.sv */
// ====================
// Pixel, sync and state types for the video output path
// ====================
`default_nettype none

package displayPkg;

  // Red in the top byte, so the struct reads as 24'hRRGGBB
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixelT;

  // Sync levels are active low, de is active high
  typedef struct packed {
    logic hSync;
    logic vSync;
    logic de;
  } syncT;

  // Idle levels outside the active area and after reset
  localparam syncT SyncIdle = '{hSync: 1'b1, vSync: 1'b1, de: 1'b0};

  typedef enum logic {
    FILL_RUN,
    FILL_DONE
  } fillStateT;

  // Bar colors, left to right on screen
  typedef enum logic [23:0] {
    WHITE   = 24'hFFFFFF,
    GREY    = 24'hEBEBEB,
    YELLOW  = 24'hFFFF00,
    CYAN    = 24'h00FFFF,
    GREEN   = 24'h00FF00,
    MAGENTA = 24'hFF00FF,
    RED     = 24'hFF0000,
    BLUE    = 24'h0000FF
  } barColorT;

endpackage

`default_nettype wire

/* frameBuffer.sv */
// ====================
// Dual-port display RAM, written one pixel at a time, read two pixels per word
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "display_macros.svh"

module frameBuffer (
  input  wire logic                    USER_CLK,
  input  wire logic                    wrEn,
  input  wire logic [`FB_WADDR_W-1:0]  wrAddr,
  input  wire logic [31:0]             wrData,
  input  wire logic                    rdEn,
  input  wire logic [`FB_ADDR_W-1:0]   rdAddr,
  output logic      [63:0]             rdData
);

  logic [63:0] mem [0:`FB_WORDS-1];

  // Lowest address bit picks the half, even pixel goes low
  always_ff @(posedge USER_CLK) begin
    if (wrEn) begin
      if (wrAddr[0]) begin
        mem[wrAddr[`FB_WADDR_W-1:1]][63:32] <= wrData;
      end else begin
        mem[wrAddr[`FB_WADDR_W-1:1]][31:0] <= wrData;
      end
    end
  end

  // Registered read, data valid the cycle after rdEn
  always_ff @(posedge USER_CLK) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

`default_nettype wire

/* testBarWriter.sv */
// ====================
// Fills the frame buffer with eight vertical color bars after reset
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "display_macros.svh"

module testBarWriter
  import displayPkg::*;
(
  input  wire logic                    USER_CLK,
  input  wire logic                    rst,
  output logic                         wrEn,
  output logic [`FB_WADDR_W-1:0]       wrAddr,
  output logic [31:0]                  wrData,
  output logic                         fillDone
);

  localparam int AddrW = `FB_WADDR_W;
  localparam int ColW = `H_CNT_W;
  localparam logic [AddrW-1:0] LastAddr = AddrW'(`FB_PIXELS - 1);
  localparam logic [ColW-1:0] LastCol = ColW'(`H_ACTIVE - 1);

  fillStateT state;
  logic [AddrW-1:0] pixAddr;
  logic [ColW-1:0] col;

  // Bar index is the column over the bar width
  function automatic pixelT barColor(input logic [ColW-1:0] column);
    barColorT bar;
    case (column / `BAR_WIDTH)
      0: bar = WHITE;
      1: bar = GREY;
      2: bar = YELLOW;
      3: bar = CYAN;
      4: bar = GREEN;
      5: bar = MAGENTA;
      6: bar = RED;
      default: bar = BLUE;
    endcase
    return pixelT'(bar);
  endfunction

  // One pixel per cycle while running
  assign wrEn = (state == FILL_RUN);
  assign wrAddr = pixAddr;
  assign wrData = {8'd0, barColor(col)};

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      state <= FILL_RUN;
      pixAddr <= '0;
      col <= '0;
      fillDone <= 1'b0;
    end else begin
      case (state)
        FILL_RUN: begin
          pixAddr <= pixAddr + 1'b1;
          col <= (col == LastCol) ? '0 : col + 1'b1;
          if (pixAddr == LastAddr) begin
            state <= FILL_DONE;
          end
        end
        default: begin
          // Flag trails the last write by one cycle
          fillDone <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* videoTiming.sv */
// ====================
// Pixel enable, raster counters and sync levels for the display
// pixelReq marks each active pixel slot for the fetch stage
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "display_macros.svh"

module videoTiming
  import displayPkg::*;
(
  input  wire logic USER_CLK,
  input  wire logic rst,
  output logic      pixelEn,
  output logic      pixelReq,
  output syncT      rawSync
);

  localparam int HW = `H_CNT_W;
  localparam int VW = `V_CNT_W;

  localparam logic [HW-1:0] HActive = HW'(`H_ACTIVE);
  localparam logic [HW-1:0] HSyncStart = HW'(`H_ACTIVE + `H_FRONT);
  localparam logic [HW-1:0] HSyncEnd = HW'(`H_ACTIVE + `H_FRONT + `H_SYNC);
  localparam logic [HW-1:0] HLast = HW'(`H_TOTAL - 1);

  localparam logic [VW-1:0] VActive = VW'(`V_ACTIVE);
  localparam logic [VW-1:0] VSyncStart = VW'(`V_ACTIVE + `V_FRONT);
  localparam logic [VW-1:0] VSyncEnd = VW'(`V_ACTIVE + `V_FRONT + `V_SYNC);
  localparam logic [VW-1:0] VLast = VW'(`V_TOTAL - 1);

  logic phase;
  logic [HW-1:0] hCnt;
  logic [VW-1:0] vCnt;
  logic inActive;
  logic hSyncOn;
  logic vSyncOn;

  // Half rate pixel slot, first slot is the second cycle after reset
  assign pixelEn = phase;

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      phase <= 1'b0;
    end else begin
      phase <= ~phase;
    end
  end

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      hCnt <= '0;
      vCnt <= '0;
    end else if (pixelEn) begin
      if (hCnt == HLast) begin
        hCnt <= '0;
        vCnt <= (vCnt == VLast) ? '0 : vCnt + 1'b1;
      end else begin
        hCnt <= hCnt + 1'b1;
      end
    end
  end

  assign inActive = (hCnt < HActive) && (vCnt < VActive);
  assign hSyncOn = (hCnt >= HSyncStart) && (hCnt < HSyncEnd);
  assign vSyncOn = (vCnt >= VSyncStart) && (vCnt < VSyncEnd);

  assign pixelReq = pixelEn & inActive;

  // Sampled every cycle so it lines up with the counters on each pixelEn
  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      rawSync <= SyncIdle;
    end else begin
      rawSync.hSync <= ~hSyncOn;
      rawSync.vSync <= ~vSyncOn;
      rawSync.de <= inActive;
    end
  end

endmodule

`default_nettype wire

/* pixelFetch.sv */
// ====================
// Reads two-pixel words from the frame buffer and unpacks them into a pixel stream
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "display_macros.svh"

module pixelFetch
  import displayPkg::*;
(
  input  wire logic                   USER_CLK,
  input  wire logic                   rst,
  input  wire logic                   pixelEn,
  input  wire logic                   pixelReq,
  input  wire syncT                   rawSync,
  output logic                        rdEn,
  output logic [`FB_ADDR_W-1:0]       rdAddr,
  input  wire logic [63:0]            rdData,
  output pixelT                       pixel
);

  localparam int AW = `FB_ADDR_W;
  localparam logic [AW-1:0] WordLast = AW'(`FB_WORDS - 1);

  logic [AW-1:0] wordAddr;
  logic frameFirst;
  logic oddCol;
  logic vSyncD;
  logic frameEdge;
  logic reqD;
  logic reqOdd;
  pixelT highHold;

  // Start of vertical sync marks a new frame
  assign frameEdge = pixelEn & vSyncD & ~rawSync.vSync;

  // Even columns fetch a new word
  assign rdEn = pixelReq & ~oddCol;
  assign rdAddr = frameFirst ? '0 : wordAddr;

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      wordAddr <= '0;
      frameFirst <= 1'b1;
      oddCol <= 1'b0;
      vSyncD <= 1'b1;
      reqD <= 1'b0;
      reqOdd <= 1'b0;
    end else begin
      reqD <= pixelReq;
      if (pixelEn) begin
        vSyncD <= rawSync.vSync;
      end
      if (pixelReq) begin
        reqOdd <= oddCol;
      end
      if (frameEdge) begin
        frameFirst <= 1'b1;
        oddCol <= 1'b0;
      end else if (pixelReq) begin
        oddCol <= ~oddCol;
        if (!oddCol) begin
          frameFirst <= 1'b0;
          wordAddr <= (rdAddr == WordLast) ? '0 : rdAddr + 1'b1;
        end
      end
    end
  end

  // Word is back one cycle after the request, pixel out the cycle after
  always_ff @(posedge USER_CLK) begin
    if (reqD) begin
      if (reqOdd) begin
        pixel <= highHold;
      end else begin
        pixel <= pixelT'(rdData[23:0]);
        highHold <= pixelT'(rdData[55:32]);
      end
    end
  end

endmodule

`default_nettype wire

/* dviEncoder.sv */
// ====================
// DVI output stage, 12-bit double data with forwarded clock pair
// ====================
`timescale 1ns/1ps
`default_nettype none

module dviEncoder
  import displayPkg::*;
(
  input  wire logic   USER_CLK,
  input  wire logic   rst,
  input  wire logic   pixelEn,
  input  wire pixelT  pixel,
  input  wire syncT   rawSync,
  output logic [11:0] DVI_D,
  output logic        DVI_XCLK_P,
  output logic        DVI_XCLK_N,
  output logic        DVI_H,
  output logic        DVI_V,
  output logic        DVI_DE,
  output logic        DVI_RESET_B
);

  logic xclkP;
  logic resetB;
  syncT syncD;
  syncT syncOut;
  pixelT pixReg;

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      xclkP <= 1'b0;
      resetB <= 1'b0;
      syncD <= SyncIdle;
      syncOut <= SyncIdle;
    end else begin
      // Clock high in the cycle after each pixel slot
      xclkP <= pixelEn;
      resetB <= 1'b1;
      if (pixelEn) begin
        // Extra pixel period covers the fetch latency
        syncD <= rawSync;
        syncOut <= syncD;
      end
    end
  end

  always_ff @(posedge USER_CLK) begin
    if (pixelEn) begin
      pixReg <= pixel;
    end
  end

  // Low half with the clock high, high half with it low
  assign DVI_D = xclkP ? pixReg[11:0] : pixReg[23:12];

  assign DVI_XCLK_P = xclkP;
  assign DVI_XCLK_N = ~xclkP;
  assign DVI_H = syncOut.hSync;
  assign DVI_V = syncOut.vSync;
  assign DVI_DE = syncOut.de;
  assign DVI_RESET_B = resetB;

endmodule

`default_nettype wire

/* displayMem.sv */
// ====================
// Top level of the video output path, from frame buffer to DVI pins
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "display_macros.svh"

module displayMem
  import displayPkg::*;
(
  input  wire logic   USER_CLK,
  input  wire logic   rst,
  output logic [11:0] DVI_D,
  output logic        DVI_XCLK_P,
  output logic        DVI_XCLK_N,
  output logic        DVI_H,
  output logic        DVI_V,
  output logic        DVI_DE,
  output logic        DVI_RESET_B,
  output logic        fillDone
);

  // Write side
  logic wrEn;
  logic [`FB_WADDR_W-1:0] wrAddr;
  logic [31:0] wrData;

  // Read side
  logic rdEn;
  logic [`FB_ADDR_W-1:0] rdAddr;
  logic [63:0] rdData;

  logic pixelEn;
  logic pixelReq;
  syncT rawSync;
  pixelT pixel;

  testBarWriter writer (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .wrEn     (wrEn),
    .wrAddr   (wrAddr),
    .wrData   (wrData),
    .fillDone (fillDone)
  );

  frameBuffer fb (
    .USER_CLK (USER_CLK),
    .wrEn     (wrEn),
    .wrAddr   (wrAddr),
    .wrData   (wrData),
    .rdEn     (rdEn),
    .rdAddr   (rdAddr),
    .rdData   (rdData)
  );

  videoTiming timing (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .pixelEn  (pixelEn),
    .pixelReq (pixelReq),
    .rawSync  (rawSync)
  );

  pixelFetch fetch (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .pixelEn  (pixelEn),
    .pixelReq (pixelReq),
    .rawSync  (rawSync),
    .rdEn     (rdEn),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .pixel    (pixel)
  );

  dviEncoder dvi (
    .USER_CLK    (USER_CLK),
    .rst         (rst),
    .pixelEn     (pixelEn),
    .pixel       (pixel),
    .rawSync     (rawSync),
    .DVI_D       (DVI_D),
    .DVI_XCLK_P  (DVI_XCLK_P),
    .DVI_XCLK_N  (DVI_XCLK_N),
    .DVI_H       (DVI_H),
    .DVI_V       (DVI_V),
    .DVI_DE      (DVI_DE),
    .DVI_RESET_B (DVI_RESET_B)
  );

endmodule

`default_nettype wire

/* tbDisplayMem.sv */
// ====================
// Self-checking testbench for the video output path
// Checks reset levels, fill time, raster timing and bar colors on the DVI pins
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "display_macros.svh"

module tbDisplayMem;

  localparam int PinDe = 0;
  localparam int PinH = 1;
  localparam int PinV = 2;
  localparam longint FillCycles = `FB_PIXELS + 1;
  localparam longint LineCycles = 2 * `H_TOTAL;
  localparam longint FrameCycles = LineCycles * `V_TOTAL;
  // Enough for the fills and the frames walked through below, with margin
  localparam longint LimitCycles = 6 * FrameCycles + 2 * FillCycles + 200;

  logic USER_CLK;
  logic rst;
  logic [11:0] DVI_D;
  logic DVI_XCLK_P;
  logic DVI_XCLK_N;
  logic DVI_H;
  logic DVI_V;
  logic DVI_DE;
  logic DVI_RESET_B;
  logic fillDone;

  longint cyc;
  longint releaseCyc;
  int errCount;
  int checkCount;
  int testCount;
  int failedTests;
  int testErrStart;
  logic [31:0] lfsr;
  logic picked [0:`V_ACTIVE-1];

  // Bar table, first column, last column and color
  int barFirst [0:7];
  int barLast [0:7];
  logic [23:0] barColor [0:7];

  displayMem uut (
    .USER_CLK    (USER_CLK),
    .rst         (rst),
    .DVI_D       (DVI_D),
    .DVI_XCLK_P  (DVI_XCLK_P),
    .DVI_XCLK_N  (DVI_XCLK_N),
    .DVI_H       (DVI_H),
    .DVI_V       (DVI_V),
    .DVI_DE      (DVI_DE),
    .DVI_RESET_B (DVI_RESET_B),
    .fillDone    (fillDone)
  );

  always #4 USER_CLK = ~USER_CLK;

  always @(posedge USER_CLK) begin
    cyc <= cyc + 1;
  end

  initial begin
    #(LimitCycles * 8);
    $display("Timeout: the run took longer than the expected frame and fill time");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic reportError(input string msg);
    $display("Error: %s", msg);
    errCount++;
  endtask

  task automatic startTest();
    testErrStart = errCount;
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errCount != testErrStart) begin
      failedTests++;
      $display("test %0d %s: %0d errors", testCount, name, errCount - testErrStart);
    end else begin
      $display("test %0d %s: ok", testCount, name);
    end
  endtask

  function automatic logic pinValue(input int which);
    case (which)
      PinDe: return DVI_DE;
      PinH: return DVI_H;
      default: return DVI_V;
    endcase
  endfunction

  // Always moves on at least one falling edge
  task automatic waitPinLevel(input int which, input logic val);
    do @(negedge USER_CLK); while (pinValue(which) !== val);
  endtask

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic pickLines();
    logic [7:0] v;
    for (int i = 0; i < `V_ACTIVE; i++) picked[i] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      v = '0;
      for (int b = 0; b < 8; b++) begin
        lfsr = lfsrStep(lfsr);
        v = {v[6:0], lfsr[0]};
      end
      picked[int'(v) % `V_ACTIVE] = 1'b1;
    end
  endtask

  task automatic holdAndRelease();
    repeat (10) @(posedge USER_CLK);
    #1 rst = 1'b0;
    releaseCyc = cyc;
    @(posedge USER_CLK);
    @(negedge USER_CLK);
    checkValue("DVI_RESET_B", 64'(DVI_RESET_B), 64'd1);
  endtask

  task automatic checkResetLevels();
    checkValue("DVI_DE", 64'(DVI_DE), 64'd0);
    checkValue("DVI_H", 64'(DVI_H), 64'd1);
    checkValue("DVI_V", 64'(DVI_V), 64'd1);
    checkValue("DVI_RESET_B", 64'(DVI_RESET_B), 64'd0);
  endtask

  // Called right after reset release
  task automatic fillTest();
    while (fillDone !== 1'b1) begin
      @(posedge USER_CLK);
      #1;
    end
    checkValue("fillDone cycles", 64'(cyc - releaseCyc), 64'(FillCycles));
  endtask

  task automatic lineTest();
    longint t0;
    longint t1;
    longint t2;
    longint t3;
    longint t4;
    waitPinLevel(PinDe, 1'b1);
    t0 = cyc;
    waitPinLevel(PinDe, 1'b0);
    t1 = cyc;
    waitPinLevel(PinH, 1'b0);
    t2 = cyc;
    waitPinLevel(PinH, 1'b1);
    t3 = cyc;
    waitPinLevel(PinDe, 1'b1);
    t4 = cyc;
    checkValue("DE high cycles", 64'(t1 - t0), 64'(2 * `H_ACTIVE));
    checkValue("H sync cycles", 64'(t3 - t2), 64'(2 * `H_SYNC));
    checkValue("line cycles", 64'(t4 - t0), 64'(LineCycles));
  endtask

  // Starts at the rising edge of V
  task automatic frameTest();
    longint t1;
    longint t2;
    longint t3;
    int lines;
    logic prevDe;
    t1 = cyc;
    lines = 0;
    prevDe = DVI_DE;
    do begin
      @(negedge USER_CLK);
      if (DVI_DE && !prevDe) lines++;
      prevDe = DVI_DE;
    end while (DVI_V !== 1'b0);
    t2 = cyc;
    waitPinLevel(PinV, 1'b1);
    t3 = cyc;
    checkValue("active lines", 64'(lines), 64'(`V_ACTIVE));
    checkValue("V sync cycles", 64'(t3 - t2), 64'(`V_SYNC * LineCycles));
    checkValue("frame cycles", 64'(t3 - t1), 64'(FrameCycles));
  endtask

  // Entered on the first cycle of DE, with the pixel clock high
  task automatic checkLine(input int line);
    logic [11:0] lo;
    logic [11:0] hi;
    for (int bar = 0; bar < 8; bar++) begin
      for (int col = barFirst[bar]; col <= barLast[bar]; col++) begin
        if (DVI_XCLK_P !== 1'b1) begin
          reportError($sformatf("pixel clock not high at line %0d column %0d", line, col));
        end
        checkValue("DVI_XCLK_N", 64'(DVI_XCLK_N), 64'd0);
        lo = DVI_D;
        @(negedge USER_CLK);
        checkValue("DVI_XCLK_P", 64'(DVI_XCLK_P), 64'd0);
        checkValue("DVI_XCLK_N", 64'(DVI_XCLK_N), 64'd1);
        hi = DVI_D;
        @(negedge USER_CLK);
        checkValue($sformatf("DVI_D pixel line %0d col %0d", line, col),
                   64'({hi, lo}), 64'(barColor[bar]));
      end
    end
    checkValue("DVI_DE after line", 64'(DVI_DE), 64'd0);
  endtask

  task automatic contentFrame();
    pickLines();
    for (int line = 0; line < `V_ACTIVE; line++) begin
      waitPinLevel(PinDe, 1'b1);
      if (picked[line]) begin
        checkLine(line);
      end else begin
        waitPinLevel(PinDe, 1'b0);
      end
    end
  endtask

  initial begin
    USER_CLK = 1'b0;
    rst = 1'b1;
    cyc = 0;
    releaseCyc = 0;
    errCount = 0;
    checkCount = 0;
    testCount = 0;
    failedTests = 0;
    lfsr = 32'h7959d98f;
    for (int i = 0; i < 8; i++) begin
      barFirst[i] = i * `BAR_WIDTH;
      barLast[i] = (i + 1) * `BAR_WIDTH - 1;
    end
    barColor[0] = 24'hFFFFFF;
    barColor[1] = 24'hEBEBEB;
    barColor[2] = 24'hFFFF00;
    barColor[3] = 24'h00FFFF;
    barColor[4] = 24'h00FF00;
    barColor[5] = 24'hFF00FF;
    barColor[6] = 24'hFF0000;
    barColor[7] = 24'h0000FF;

    startTest();
    repeat (2) @(negedge USER_CLK);
    checkResetLevels();
    holdAndRelease();
    finishTest("reset levels");

    startTest();
    fillTest();
    finishTest("fill time");

    // Skip to a frame that starts after the fill
    waitPinLevel(PinV, 1'b0);
    waitPinLevel(PinV, 1'b1);
    startTest();
    fork
      lineTest();
      frameTest();
    join
    finishTest("line and frame timing");

    startTest();
    contentFrame();
    finishTest("pixel content");

    startTest();
    waitPinLevel(PinDe, 1'b1);
    repeat (20) @(posedge USER_CLK);
    #1 rst = 1'b1;
    @(negedge USER_CLK);
    checkResetLevels();
    // Last word holds the two rightmost pixels of the bottom line
    checkValue("frame buffer last word", uut.fb.mem[`FB_WORDS-1],
               {8'd0, barColor[7], 8'd0, barColor[7]});
    holdAndRelease();
    fillTest();
    waitPinLevel(PinV, 1'b0);
    waitPinLevel(PinV, 1'b1);
    fork
      lineTest();
      contentFrame();
    join
    finishTest("reset mid-frame");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, failedTests, checkCount, errCount);
    if (errCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
displayPkg.sv
frameBuffer.sv
testBarWriter.sv
videoTiming.sv
pixelFetch.sv
dviEncoder.sv
displayMem.sv
tbDisplayMem.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module tbDisplayMem -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
